/* dv/sm_control_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module sm_control_tb
    import sm_pkg::*;
    import mem_pkg::*;
();

    localparam int CMD_ID = 0;
    localparam int CMD_PREV = 1;
    localparam int CMD_DISABLE = 2;
    localparam int MAX_WORDS = 12;
    localparam int NUM_CMDS = 40;
    // two ranges at up to four cycles a word, plus command overhead
    localparam int TIMEOUT_CYCLES = NUM_CMDS * (2 * MAX_WORDS * 4 + 20);

    logic      clk;
    logic      reset;
    logic      start;
    logic      cmd_disable;
    logic      cmd_id;
    logic      cmd_id_prev;
    word_t     pc;
    word_t     r15;
    word_t     sm_data;
    word_t     sm_prev_id;
    logic      sm_data_select_valid;
    logic      sm_key_select_valid;
    logic      mem_credit;
    logic      busy;
    sm_req_t   sm_request;
    word_t     sm_data_select;
    logic      mem_clear;
    mem_word_t mab;
    logic      reg_write;
    word_t     dest_reg;
    word_t     reg_data;

    // module table entry for the current command
    word_t       tbl_pub_start;
    word_t       tbl_pub_end;
    word_t       tbl_sec_start;
    word_t       tbl_sec_end;
    word_t       tbl_id;
    word_t       exp_select;
    mem_word_t   clear_log[$];
    int          credit_due[$];
    int          cycle = 0;
    logic [31:0] stim_seed;
    logic [31:0] credit_seed;

    sm_control i_sm_control (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function int unsigned rand_below(input int unsigned span);
        stim_seed = lcg_next(stim_seed);
        return stim_seed[31:16] % span;
    endfunction

    function automatic int range_words(input word_t first, input word_t last);
        return (last > first) ? int'(last - first) / 2 : 0;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        assert (actual == expected)
        else
            report_failure($sformatf("Mismatch at time %0t: %s expected %h, actual %h",
                                     $time, name, expected, actual));
    endtask

    task automatic check_reset_state();
        check_value("busy", 16'd0, word_t'(busy));
        check_value("reg_write", 16'd0, word_t'(reg_write));
        check_value("mem_clear", 16'd0, word_t'(mem_clear));
        check_value("sm_request", word_t'(SM_REQ_NONE), word_t'(sm_request));
        check_value("dest_reg", 16'd0, dest_reg);
        check_value("reg_data", 16'd0, reg_data);
    endtask

    // result write is a single-cycle pulse
    assert property (@(posedge clk) disable iff (reset) reg_write |=> !reg_write)
    else
        report_failure("reg_write stayed high for more than one cycle");

    assert property (@(posedge clk) disable iff (reset) mem_clear |-> busy)
    else
        report_failure("mem_clear was raised while the controller was idle");

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES)
            report_failure("timeout, the commands did not finish within the cycle limit");
    end

    // module table, credit return and memory monitor
    always @(negedge clk)
    begin
        case (sm_request)
            SM_REQ_PUBSTART: sm_data = tbl_pub_start;
            SM_REQ_PUBEND:   sm_data = tbl_pub_end;
            SM_REQ_SECSTART: sm_data = tbl_sec_start;
            SM_REQ_SECEND:   sm_data = tbl_sec_end;
            SM_REQ_ID:       sm_data = tbl_id;
            default:         sm_data = 16'hffff;
        endcase
        if (busy)
            check_value("sm_data_select", exp_select, sm_data_select);
        assert (!(mem_clear && credit_due.size() >= int'(MEM_CREDITS)))
        else
            report_failure("mem_clear was raised while every write credit was outstanding");
        if (reg_write)
        begin
            assert (credit_due.size() == 0)
            else
                report_failure("result was written before all clear writes were credited");
        end
        mem_credit = 1'b0;
        if (credit_due.size() > 0 && credit_due[0] <= cycle)
        begin
            mem_credit = 1'b1;
            void'(credit_due.pop_front());
        end
        if (mem_clear)
        begin
            clear_log.push_back(mab);
            credit_seed = lcg_next(credit_seed);
            credit_due.push_back(cycle + 1 + int'(credit_seed[29:28]));
        end
    end

    task automatic run_command(input int kind, input logic check_ok, input int pub_words,
                               input int sec_words, input logic invert);
        word_t exp_data;
        word_t exp_addr;
        logic  cleared;
        int    pub_n;
        int    n;
        cleared = (kind == CMD_DISABLE) && check_ok;
        tbl_pub_start = 16'h0100 + (word_t'(rand_below(2048)) << 1);
        tbl_pub_end = invert ? tbl_pub_start - 16'd4 : tbl_pub_start + word_t'(2 * pub_words);
        tbl_sec_start = 16'h4000 + (word_t'(rand_below(2048)) << 1);
        tbl_sec_end = tbl_sec_start + word_t'(2 * sec_words);
        tbl_id = word_t'(rand_below(65536));
        pc = word_t'(rand_below(65536));
        r15 = tbl_pub_start + (word_t'(rand_below(MAX_WORDS)) << 1);
        sm_prev_id = word_t'(rand_below(65536));
        cmd_id = kind == CMD_ID;
        cmd_id_prev = kind == CMD_PREV;
        cmd_disable = kind == CMD_DISABLE;
        // validity bits that the command ignores are random
        sm_data_select_valid = (kind == CMD_ID) ? check_ok : rand_below(2) != 0;
        sm_key_select_valid = (kind == CMD_DISABLE) ? check_ok : rand_below(2) != 0;
        exp_select = (kind == CMD_ID) ? r15 : pc;
        clear_log.delete();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (cleared)
        begin
            while (!reg_write)
                @(negedge clk);
        end
        else
        begin
            repeat (2)
            begin
                check_value("reg_write", 16'd0, word_t'(reg_write));
                @(negedge clk);
            end
            check_value("reg_write", 16'd1, word_t'(reg_write));
        end
        if (kind != CMD_PREV && !check_ok)
            exp_data = 16'h0000;
        else if (kind == CMD_ID)
            exp_data = tbl_id;
        else if (kind == CMD_PREV)
            exp_data = sm_prev_id;
        else
            exp_data = r15;
        check_value("dest_reg", cleared ? 16'h0001 : 16'h8000, dest_reg);
        check_value("reg_data", exp_data, reg_data);
        check_value("busy", 16'd0, word_t'(busy));
        // public range first, then the secret range
        pub_n = range_words(tbl_pub_start, tbl_pub_end);
        n = cleared ? pub_n + range_words(tbl_sec_start, tbl_sec_end) : 0;
        check_value("mem_clear count", word_t'(n), word_t'(clear_log.size()));
        for (int idx = 0; idx < n; idx++)
        begin
            if (idx < pub_n)
                exp_addr = tbl_pub_start + word_t'(2 * idx);
            else
                exp_addr = tbl_sec_start + word_t'(2 * (idx - pub_n));
            check_value("mab", exp_addr, clear_log[idx]);
        end
        @(negedge clk);
    endtask

    initial
    begin
        reset = 1'b1;
        start = 1'b0;
        cmd_disable = 1'b0;
        cmd_id = 1'b0;
        cmd_id_prev = 1'b0;
        pc = '0;
        r15 = '0;
        sm_data = '0;
        sm_prev_id = '0;
        sm_data_select_valid = 1'b0;
        sm_key_select_valid = 1'b0;
        mem_credit = 1'b0;
        exp_select = '0;
        stim_seed = 32'd33641;
        credit_seed = 32'd33641;
        repeat (10) @(negedge clk);
        check_reset_state();
        reset = 1'b0;
        @(negedge clk);
        check_reset_state();
        run_command(CMD_ID, 1'b1, 4, 4, 1'b0);
        run_command(CMD_PREV, 1'b0, 4, 4, 1'b0);
        run_command(CMD_ID, 1'b0, 4, 4, 1'b0);
        run_command(CMD_DISABLE, 1'b0, 4, 4, 1'b0);
        // empty public, empty secret, inverted public, then the largest ranges
        run_command(CMD_DISABLE, 1'b1, 0, 5, 1'b0);
        run_command(CMD_DISABLE, 1'b1, 6, 0, 1'b0);
        run_command(CMD_DISABLE, 1'b1, 3, 3, 1'b1);
        run_command(CMD_DISABLE, 1'b1, MAX_WORDS, MAX_WORDS, 1'b0);
        for (int i = 8; i < NUM_CMDS; i++)
            run_command(int'(rand_below(3)), rand_below(4) != 0, int'(rand_below(MAX_WORDS + 1)),
                        int'(rand_below(MAX_WORDS + 1)), 1'b0);
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
verilog/sm_pkg.sv
verilog/mem_pkg.sv
verilog/range_clear_if.sv
verilog/sm_check.sv
verilog/range_clear.sv
verilog/protect_sequencer.sv
verilog/sm_control.sv
dv/sm_control_tb.sv

/* run.sh */
#!/bin/sh
set -e

verilator --binary --assert -Wno-fatal --top-module sm_control_tb -f files.f \
    --Mdir obj_dir -o sm_control_sim

./obj_dir/sm_control_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0

/* verilog/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // byte address of one memory word
    typedef logic [15:0] mem_word_t;

    // words are two bytes apart
    localparam mem_word_t ADDR_STEP = 16'd2;

    // holds 0 to MEM_CREDITS
    typedef logic [2:0] credit_t;

    // clear writes allowed in flight
    localparam credit_t MEM_CREDITS = 3'd4;

endpackage

`default_nettype wire

/* verilog/protect_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module protect_sequencer
    import sm_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  logic             cmd_disable,
    input  logic             cmd_id_prev,
    input  logic             sm_valid,
    input  word_t            sm_data,
    input  word_t            sm_prev_id,
    input  word_t            r15,
    range_clear_if.sequencer clr,
    output logic             busy,
    output sm_req_t          sm_request,
    output logic             reg_write,
    output word_t            dest_reg,
    output word_t            reg_data
);

    typedef enum logic [3:0] {
        IDLE             = 4'd0,
        CHECK            = 4'd1,
        CLEAR_CODE_START = 4'd2,
        CLEAR_CODE_END   = 4'd3,
        CLEAR_CODE       = 4'd4,
        CLEAR_DATA_START = 4'd5,
        CLEAR_DATA_END   = 4'd6,
        CLEAR_DATA       = 4'd7,
        FAIL             = 4'd8,
        SUCCESS          = 4'd9
    } state_t;

    state_t state;
    state_t next_state;
    logic   set_result;
    word_t  dest_val;
    word_t  data_val;

    always_comb
    begin
        case (state)
            IDLE:
                next_state = start ? CHECK : IDLE;
            CHECK:
            begin
                if (!sm_valid)
                    next_state = FAIL;
                else if (cmd_disable)
                    next_state = CLEAR_CODE_START;
                else
                    next_state = SUCCESS;
            end
            CLEAR_CODE_START:
                next_state = CLEAR_CODE_END;
            CLEAR_CODE_END:
                next_state = CLEAR_CODE;
            CLEAR_CODE:
                next_state = clr.done ? CLEAR_DATA_START : CLEAR_CODE;
            CLEAR_DATA_START:
                next_state = CLEAR_DATA_END;
            CLEAR_DATA_END:
                next_state = CLEAR_DATA;
            CLEAR_DATA:
                next_state = clr.done ? SUCCESS : CLEAR_DATA;
            FAIL:
                next_state = IDLE;
            SUCCESS:
                next_state = IDLE;
            default:
                next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= IDLE;
        else
            state <= next_state;
    end

    // table answers on sm_data within the cycle of the request
    assign clr.bound = sm_data;

    always_comb
    begin
        busy           = 1'b1;
        sm_request     = SM_REQ_NONE;
        clr.load_base  = 1'b0;
        clr.load_limit = 1'b0;
        clr.run        = 1'b0;
        set_result     = 1'b0;
        dest_val       = RESULT_REG_DEFAULT;
        data_val       = RESULT_FAIL_DATA;

        case (state)
            IDLE:
                busy = 1'b0;

            CLEAR_CODE_START:
            begin
                sm_request    = SM_REQ_PUBSTART;
                clr.load_base = 1'b1;
            end

            CLEAR_CODE_END:
            begin
                sm_request     = SM_REQ_PUBEND;
                clr.load_limit = 1'b1;
            end

            CLEAR_CODE:
                clr.run = 1'b1;

            CLEAR_DATA_START:
            begin
                sm_request    = SM_REQ_SECSTART;
                clr.load_base = 1'b1;
            end

            CLEAR_DATA_END:
            begin
                sm_request     = SM_REQ_SECEND;
                clr.load_limit = 1'b1;
            end

            CLEAR_DATA:
                clr.run = 1'b1;

            FAIL:
                set_result = 1'b1;

            SUCCESS:
            begin
                sm_request = SM_REQ_ID;
                set_result = 1'b1;
                if (cmd_disable)
                begin
                    dest_val = RESULT_REG_DISABLE;
                    data_val = r15;
                end
                else if (cmd_id_prev)
                    data_val = sm_prev_id;
                else
                    data_val = sm_data;
            end

            default:
            begin
            end
        endcase
    end

    // one-cycle write to the register file
    always_ff @(posedge clk)
    begin
        if (reset || !set_result)
        begin
            reg_write <= 1'b0;
            dest_reg  <= '0;
            reg_data  <= '0;
        end
        else
        begin
            reg_write <= 1'b1;
            dest_reg  <= dest_val;
            reg_data  <= data_val;
        end
    end

endmodule

`default_nettype wire

/* verilog/range_clear.sv */
`timescale 1ns/10ps
`default_nettype none

module range_clear
    import mem_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    range_clear_if.clearer ctl,
    input  logic           mem_credit,
    output logic           mem_clear,
    output mem_word_t      mab
);

    mem_word_t addr;
    mem_word_t limit;
    credit_t   credits;
    logic      run_q;
    logic      words_left;
    logic      no_credit;

    // limit is exclusive, so an inverted range is simply empty
    assign words_left = addr < limit;
    assign no_credit  = credits == '0;

    assign ctl.stall = ctl.run && words_left && no_credit;

    // wait for every outstanding write before reporting the range done
    assign ctl.done = ctl.run && !words_left && (credits == MEM_CREDITS);

    // first write one cycle after run rises
    assign mem_clear = run_q && ctl.run && words_left && !ctl.stall;
    assign mab       = addr;

    always_ff @(posedge clk)
    begin
        if (reset)
            run_q <= 1'b0;
        else
            run_q <= ctl.run;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            addr <= '0;
        else if (ctl.load_base)
            addr <= ctl.bound;
        else if (mem_clear)
            addr <= addr + ADDR_STEP;
    end

    always_ff @(posedge clk)
    begin
        if (ctl.load_limit)
            limit <= ctl.bound;
    end

    // spend and return in one cycle leave the count unchanged
    always_ff @(posedge clk)
    begin
        if (reset)
            credits <= MEM_CREDITS;
        else if (mem_clear && !mem_credit)
            credits <= credits - 1'b1;
        else if (mem_credit && !mem_clear)
            credits <= credits + 1'b1;
    end

endmodule

`default_nettype wire

/* verilog/range_clear_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface range_clear_if
    import mem_pkg::*;
();

    logic      load_base;
    logic      load_limit;
    mem_word_t bound;
    logic      run;
    logic      done;
    logic      stall;

    modport sequencer (
        output load_base,
        output load_limit,
        output bound,
        output run,
        input  done,
        input  stall
    );

    modport clearer (
        input  load_base,
        input  load_limit,
        input  bound,
        input  run,
        output done,
        output stall
    );

endinterface

`default_nettype wire

/* verilog/sm_check.sv */
`timescale 1ns/10ps
`default_nettype none

module sm_check
    import sm_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  cmd_id,
    input  logic  cmd_disable,
    input  word_t pc,
    input  word_t r15,
    input  logic  sm_data_select_valid,
    input  logic  sm_key_select_valid,
    output word_t sm_data_select,
    output logic  sm_valid
);

    logic valid_next;

    // id looks up the address in r15, everything else the caller
    assign sm_data_select = cmd_id ? r15 : pc;

    always_comb
    begin
        if (cmd_id)
            valid_next = sm_data_select_valid;
        else if (cmd_disable)
            // caller must itself be a module
            valid_next = sm_key_select_valid;
        else
            valid_next = 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            sm_valid <= 1'b0;
        else
            sm_valid <= valid_next;
    end

endmodule

`default_nettype wire

/* verilog/sm_control.sv */
`timescale 1ns/10ps
`default_nettype none

module sm_control
    import sm_pkg::*;
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start,
    input  logic      cmd_disable,
    input  logic      cmd_id,
    input  logic      cmd_id_prev,
    input  word_t     pc,
    input  word_t     r15,
    input  word_t     sm_data,
    input  word_t     sm_prev_id,
    input  logic      sm_data_select_valid,
    input  logic      sm_key_select_valid,
    input  logic      mem_credit,
    output logic      busy,
    output sm_req_t   sm_request,
    output word_t     sm_data_select,
    output logic      mem_clear,
    output mem_word_t mab,
    output logic      reg_write,
    output word_t     dest_reg,
    output word_t     reg_data
);

    logic sm_valid;

    range_clear_if clr_bus ();

    sm_check i_sm_check (
        .clk                  (clk),
        .reset                (reset),
        .cmd_id               (cmd_id),
        .cmd_disable          (cmd_disable),
        .pc                   (pc),
        .r15                  (r15),
        .sm_data_select_valid (sm_data_select_valid),
        .sm_key_select_valid  (sm_key_select_valid),
        .sm_data_select       (sm_data_select),
        .sm_valid             (sm_valid)
    );

    range_clear i_range_clear (
        .clk        (clk),
        .reset      (reset),
        .ctl        (clr_bus),
        .mem_credit (mem_credit),
        .mem_clear  (mem_clear),
        .mab        (mab)
    );

    protect_sequencer i_protect_sequencer (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .cmd_disable (cmd_disable),
        .cmd_id_prev (cmd_id_prev),
        .sm_valid    (sm_valid),
        .sm_data     (sm_data),
        .sm_prev_id  (sm_prev_id),
        .r15         (r15),
        .clr         (clr_bus),
        .busy        (busy),
        .sm_request  (sm_request),
        .reg_write   (reg_write),
        .dest_reg    (dest_reg),
        .reg_data    (reg_data)
    );

endmodule

`default_nettype wire

/* verilog/sm_pkg.sv */
`default_nettype none

package sm_pkg;

    // processor word for registers, module ids and addresses
    typedef logic [15:0] word_t;

    // requests to the module table
    typedef enum logic [2:0] {
        SM_REQ_NONE     = 3'd0,
        SM_REQ_PUBSTART = 3'd1,
        SM_REQ_PUBEND   = 3'd2,
        SM_REQ_SECSTART = 3'd3,
        SM_REQ_SECEND   = 3'd4,
        SM_REQ_ID       = 3'd5
    } sm_req_t;

    // destination register codes
    localparam word_t RESULT_REG_DEFAULT = 16'h8000;
    localparam word_t RESULT_REG_DISABLE = 16'h0001;

    // returned on a failed command
    localparam word_t RESULT_FAIL_DATA = 16'h0000;

endpackage

`default_nettype wire
